// ==== mem_lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_lane_if ();

    import mem_pkg::*;

    aluop_t op;             // lane alu op
    word_t  addr;           // memory address, low bits pick the byte
    word_t  alu_result;     // value for non-loads
    logic   is_load;        // op decoded as a load
    logic   data_grant;     // cache read word valid this cycle
    word_t  wb_data;        // formed writeback data

    modport src (
        output op,
        output addr,
        output alu_result,
        input  wb_data
    );

    modport lane (
        input  op,
        input  addr,
        input  alu_result,
        input  data_grant,
        output is_load,
        output wb_data
    );

    modport ctrl (
        input  is_load,
        output data_grant
    );

endinterface

`default_nettype wire

// ==== mem_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_load_align (
    input  logic            clk,
    input  logic            arst_n_i,
    input  mem_pkg::word_t  rdata_i,        // shared cache read word
    mem_lane_if.lane        lane
);

    import mem_pkg::*;

    localparam int BYTE_W = 8;
    localparam int HALF_W = 16;

    byte_off_t              off;            // byte offset from address
    logic [BYTE_W-1:0]      sel_byte;       // addressed byte
    logic [HALF_W-1:0]      sel_half;       // addressed halfword
    logic                   half_aligned;   // halfword on an even offset
    logic                   half_op;        // ldh or ldhu
    word_t                  load_data;      // extended load result

    assign off = lane.addr[$bits(byte_off_t)-1:0];

    always_comb begin
        case (off)
            2'd0: begin
                sel_byte = rdata_i[7:0];
            end
            2'd1: begin
                sel_byte = rdata_i[15:8];
            end
            2'd2: begin
                sel_byte = rdata_i[23:16];
            end
            default: begin
                sel_byte = rdata_i[31:24];
            end
        endcase
    end

    assign sel_half     = off[1] ? rdata_i[31:16] : rdata_i[15:0];  // upper or lower half
    assign half_aligned = ~off[0];

    // op decode and extension
    always_comb begin
        lane.is_load = 1'b1;
        load_data    = '0;
        case (lane.op)
            `MEM_ALU_LDB: begin
                load_data = {{(`MEM_DATA_W-BYTE_W){sel_byte[BYTE_W-1]}}, sel_byte};
            end
            `MEM_ALU_LDBU: begin
                load_data = {{(`MEM_DATA_W-BYTE_W){1'b0}}, sel_byte};
            end
            `MEM_ALU_LDH: begin
                if (half_aligned) begin
                    load_data = {{(`MEM_DATA_W-HALF_W){sel_half[HALF_W-1]}}, sel_half};
                end
            end
            `MEM_ALU_LDHU: begin
                if (half_aligned) begin
                    load_data = {{(`MEM_DATA_W-HALF_W){1'b0}}, sel_half};
                end
            end
            `MEM_ALU_LDW, `MEM_ALU_LLW: begin
                load_data = rdata_i;            // whole word, no shaping
            end
            default: begin
                lane.is_load = 1'b0;            // not a load
            end
        endcase
    end

    // writeback select
    always_comb begin
        if (!lane.is_load) begin
            lane.wb_data = lane.alu_result;     // pass-through
        end else if (lane.data_grant) begin
            lane.wb_data = load_data;
        end else begin
            lane.wb_data = '0;                  // still waiting on the cache
        end
    end

    assign half_op = (lane.op == `MEM_ALU_LDH) || (lane.op == `MEM_ALU_LDHU);

    // misaligned halfword never leaks cache bytes, grant comes from the controller
    a_half_odd_zero: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (half_op && off[0] && lane.data_grant) |-> (lane.wb_data == '0)
    );

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0]     word_t;        // one data word
    typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;    // register number
    typedef logic [`MEM_ALUOP_W-1:0]    aluop_t;       // alu op code
    typedef logic [`MEM_EXC_W-1:0]      exc_in_t;      // flags from earlier stages

    // one bit wider, bit 0 belongs to the commit stage
    typedef logic [`MEM_EXC_W:0]        exc_commit_t;

    typedef logic [$clog2(`MEM_DATA_W/8)-1:0] byte_off_t;  // byte inside a word

endpackage

`default_nettype wire

// ==== mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// widths

`define MEM_DATA_W      32      // data word
`define MEM_REG_ADDR_W  5       // register number
`define MEM_ALUOP_W     8       // alu op code
`define MEM_EXC_W       5       // exception flags from earlier stages

// load op codes

`define MEM_ALU_LDB     8'h28   // byte, sign extended
`define MEM_ALU_LDH     8'h29   // halfword, sign extended
`define MEM_ALU_LDW     8'h2a   // word
`define MEM_ALU_LDBU    8'h2c   // byte, zero extended
`define MEM_ALU_LDHU    8'h2d   // halfword, zero extended
`define MEM_ALU_LLW     8'h30   // load-linked word

// every other op code is treated as a non-load
// and passes its alu result through to writeback

`endif

// ==== mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,

    // from execute
    input  logic [1:0]              valid_i,
    input  logic [1:0]              is_privilege_i,
    input  logic [1:0]              is_ertn_i,
    input  logic [1:0]              is_idle_i,
    input  logic [1:0]              reg_write_en_i,
    input  mem_pkg::word_t          pc0_i,
    input  mem_pkg::word_t          pc1_i,
    input  mem_pkg::word_t          mem_addr0_i,
    input  mem_pkg::word_t          mem_addr1_i,
    input  mem_pkg::word_t          reg_write_data0_i,      // alu result
    input  mem_pkg::word_t          reg_write_data1_i,
    input  mem_pkg::reg_addr_t      reg_write_addr0_i,
    input  mem_pkg::reg_addr_t      reg_write_addr1_i,
    input  mem_pkg::aluop_t         aluop0_i,
    input  mem_pkg::aluop_t         aluop1_i,
    input  mem_pkg::exc_in_t        exc0_i,
    input  mem_pkg::exc_in_t        exc1_i,

    // data cache
    input  mem_pkg::word_t          dcache_rdata_i,
    input  logic                    data_ok_i,

    // pipeline control
    output logic                    pause_mem_o,

    // writeback
    output logic [1:0]              wb_reg_write_en_o,
    output mem_pkg::reg_addr_t      wb_reg_write_addr0_o,
    output mem_pkg::reg_addr_t      wb_reg_write_addr1_o,
    output mem_pkg::word_t          wb_reg_write_data0_o,
    output mem_pkg::word_t          wb_reg_write_data1_o,

    // commit
    output logic [1:0]              commit_valid_o,
    output logic [1:0]              commit_privilege_o,
    output logic [1:0]              commit_ertn_o,
    output logic [1:0]              commit_idle_o,
    output mem_pkg::word_t          commit_pc0_o,
    output mem_pkg::word_t          commit_pc1_o,
    output mem_pkg::word_t          commit_addr0_o,
    output mem_pkg::word_t          commit_addr1_o,
    output mem_pkg::exc_commit_t    commit_exc0_o,
    output mem_pkg::exc_commit_t    commit_exc1_o
);

    import mem_pkg::*;

    mem_lane_if lane0_bus ();
    mem_lane_if lane1_bus ();

    // lane 0 request
    assign lane0_bus.op         = aluop0_i;
    assign lane0_bus.addr       = mem_addr0_i;
    assign lane0_bus.alu_result = reg_write_data0_i;

    // lane 1 request
    assign lane1_bus.op         = aluop1_i;
    assign lane1_bus.addr       = mem_addr1_i;
    assign lane1_bus.alu_result = reg_write_data1_i;

    mem_load_align lane0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rdata_i  (dcache_rdata_i),
        .lane     (lane0_bus.lane)
    );

    mem_load_align lane1 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rdata_i  (dcache_rdata_i),
        .lane     (lane1_bus.lane)
    );

    mem_stall_ctrl ctrl0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .data_ok_i   (data_ok_i),
        .exc0_i      (exc0_i),
        .exc1_i      (exc1_i),
        .lane0       (lane0_bus.ctrl),
        .lane1       (lane1_bus.ctrl),
        .pause_mem_o (pause_mem_o)
    );

    assign wb_reg_write_en_o    = reg_write_en_i;
    assign wb_reg_write_addr0_o = reg_write_addr0_i;
    assign wb_reg_write_addr1_o = reg_write_addr1_i;
    assign wb_reg_write_data0_o = lane0_bus.wb_data;
    assign wb_reg_write_data1_o = lane1_bus.wb_data;

    assign commit_valid_o     = valid_i;
    assign commit_privilege_o = is_privilege_i;
    assign commit_ertn_o      = is_ertn_i;
    assign commit_idle_o      = is_idle_i;
    assign commit_pc0_o       = pc0_i;
    assign commit_pc1_o       = pc1_i;
    assign commit_addr0_o     = mem_addr0_i;
    assign commit_addr1_o     = mem_addr1_i;

    // this stage raises no exception of its own
    assign commit_exc0_o = exc_commit_t'({exc0_i, 1'b0});
    assign commit_exc1_o = exc_commit_t'({exc1_i, 1'b0});

endmodule

`default_nettype wire

// ==== mem_stall_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stall_ctrl (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                data_ok_i,      // cache read word valid
    input  mem_pkg::exc_in_t    exc0_i,
    input  mem_pkg::exc_in_t    exc1_i,
    mem_lane_if.ctrl            lane0,
    mem_lane_if.ctrl            lane1,
    output logic                pause_mem_o     // stall request to pipeline control
);

    import mem_pkg::*;

    localparam exc_in_t EXC_NONE = '0;

    logic any_load;         // some lane holds a load
    logic load_waiting;     // load without cache data
    logic exc_seen;         // a lane carries an exception

    // both lanes share the one cache port
    assign lane0.data_grant = data_ok_i;
    assign lane1.data_grant = data_ok_i;

    assign any_load     = lane0.is_load | lane1.is_load;
    assign load_waiting = any_load & ~data_ok_i;

    assign exc_seen = (exc0_i != EXC_NONE) | (exc1_i != EXC_NONE);

    // a faulting instruction must not wait for memory
    assign pause_mem_o = load_waiting & ~exc_seen;

    a_pause_no_data: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pause_mem_o |-> !data_ok_i
    );

    // is_load comes from the aligner lanes
    a_pause_has_load: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pause_mem_o |-> (lane0.is_load || lane1.is_load)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
mem_pkg.sv
mem_lane_if.sv
mem_load_align.sv
mem_stall_ctrl.sv
mem_stage.sv
tb_mem_stage.sv

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module tb_mem_stage;

    import mem_pkg::*;

    localparam int CLK_HALF     = 20;       // ns
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_SLACK   = 4;        // spare cycles a wait may take

    localparam aluop_t LOAD_OPS [6] = '{`MEM_ALU_LDB, `MEM_ALU_LDBU, `MEM_ALU_LDH,
                                        `MEM_ALU_LDHU, `MEM_ALU_LDW, `MEM_ALU_LLW};

    logic           clk;
    logic           arst_n_i;
    logic [1:0]     valid_i;
    logic [1:0]     is_privilege_i;
    logic [1:0]     is_ertn_i;
    logic [1:0]     is_idle_i;
    logic [1:0]     reg_write_en_i;
    word_t          pc0_i;
    word_t          pc1_i;
    word_t          mem_addr0_i;
    word_t          mem_addr1_i;
    word_t          reg_write_data0_i;
    word_t          reg_write_data1_i;
    reg_addr_t      reg_write_addr0_i;
    reg_addr_t      reg_write_addr1_i;
    aluop_t         aluop0_i;
    aluop_t         aluop1_i;
    exc_in_t        exc0_i;
    exc_in_t        exc1_i;
    word_t          dcache_rdata_i;
    logic           data_ok_i;
    logic           pause_mem_o;
    logic [1:0]     wb_reg_write_en_o;
    reg_addr_t      wb_reg_write_addr0_o;
    reg_addr_t      wb_reg_write_addr1_o;
    word_t          wb_reg_write_data0_o;
    word_t          wb_reg_write_data1_o;
    logic [1:0]     commit_valid_o;
    logic [1:0]     commit_privilege_o;
    logic [1:0]     commit_ertn_o;
    logic [1:0]     commit_idle_o;
    word_t          commit_pc0_o;
    word_t          commit_pc1_o;
    word_t          commit_addr0_o;
    word_t          commit_addr1_o;
    exc_commit_t    commit_exc0_o;
    exc_commit_t    commit_exc1_o;

    word_t          exp_wb0;
    word_t          exp_wb1;
    logic           exp_pause;
    exc_commit_t    exp_exc0;
    exc_commit_t    exp_exc1;
    integer         seed;
    string          test_name;

    mem_stage dut0 (.*);

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic logic is_load_op(input aluop_t op);
        foreach (LOAD_OPS[i]) begin
            if (op == LOAD_OPS[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // expected writeback data for one lane
    function automatic word_t model_wb(input aluop_t op, input word_t addr, input word_t rdata,
                                       input logic ok, input word_t alu);
        word_t   lanes;
        byte     sb;
        shortint sh;
        lanes = rdata >> (8 * addr[1:0]);       // addressed byte moved to the bottom
        sb    = lanes[7:0];
        sh    = lanes[15:0];
        if (!is_load_op(op)) begin
            return alu;
        end
        if (!ok) begin
            return '0;
        end
        if (op == `MEM_ALU_LDB) begin
            return word_t'(int'(sb));
        end
        if (op == `MEM_ALU_LDBU) begin
            return word_t'(lanes[7:0]);
        end
        if ((op == `MEM_ALU_LDH || op == `MEM_ALU_LDHU) && addr[0]) begin
            return '0;                          // odd halfword
        end
        if (op == `MEM_ALU_LDH) begin
            return word_t'(int'(sh));
        end
        if (op == `MEM_ALU_LDHU) begin
            return word_t'(lanes[15:0]);
        end
        return rdata;
    endfunction

    assign exp_wb0   = model_wb(aluop0_i, mem_addr0_i, dcache_rdata_i, data_ok_i, reg_write_data0_i);
    assign exp_wb1   = model_wb(aluop1_i, mem_addr1_i, dcache_rdata_i, data_ok_i, reg_write_data1_i);
    assign exp_pause = (is_load_op(aluop0_i) || is_load_op(aluop1_i)) && !data_ok_i
                       && exc0_i == '0 && exc1_i == '0;
    assign exp_exc0  = exc_commit_t'(exc0_i) << 1;
    assign exp_exc1  = exc_commit_t'(exc1_i) << 1;

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_value(input string what, input logic [127:0] exp, input logic [127:0] act);
        $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        stop_run();
    endtask

    task automatic wait_falls(input int n);
        time t_limit;
        int  seen;
        seen    = 0;
        t_limit = $time + (n + WAIT_SLACK) * 2 * CLK_HALF;
        while (seen < n && $time <= t_limit) begin
            @(negedge clk);
            seen++;
        end
        if (seen < n) begin
            $display("timeout: clock gave %0d of %0d falling edges in time", seen, n);
            stop_run();
        end
    endtask

    // random commit side band with non-load ops and no exceptions
    task automatic randomize_sideband();
        valid_i           = 2'(rand_word());
        is_privilege_i    = 2'(rand_word());
        is_ertn_i         = 2'(rand_word());
        is_idle_i         = 2'(rand_word());
        reg_write_en_i    = 2'(rand_word());
        pc0_i             = rand_word();
        pc1_i             = rand_word();
        mem_addr0_i       = rand_word();
        mem_addr1_i       = rand_word();
        reg_write_data0_i = rand_word();
        reg_write_data1_i = rand_word();
        reg_write_addr0_i = reg_addr_t'(rand_word());
        reg_write_addr1_i = reg_addr_t'(rand_word());
        aluop0_i          = aluop_t'(rand_word()) & 8'h1f;    // below every load code
        aluop1_i          = aluop_t'(rand_word()) & 8'h1f;
        exc0_i            = '0;
        exc1_i            = '0;
        dcache_rdata_i    = rand_word();
    endtask

    task automatic load_sweep(input string name, input aluop_t op_a, input aluop_t op_b);
        aluop_t op;
        test_name = name;
        for (int o = 0; o < 2; o++) begin
            op = (o == 0) ? op_a : op_b;
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 2; k++) begin
                    randomize_sideband();
                    aluop0_i         = op;
                    aluop1_i         = op;
                    mem_addr0_i[1:0] = byte_off_t'(off);
                    mem_addr1_i[1:0] = byte_off_t'(3 - off);
                    if (k == 0) begin
                        dcache_rdata_i = dcache_rdata_i | 32'h8080_8080;  // sign bits set
                    end else begin
                        dcache_rdata_i = dcache_rdata_i & 32'h7f7f_7f7f;
                    end
                    data_ok_i = 1'b1;
                    wait_falls(1);
                end
            end
        end
    endtask

    a_wb0: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_reg_write_data0_o == exp_wb0)
        else fail_value("wb data lane 0", exp_wb0, wb_reg_write_data0_o);
    a_wb1: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_reg_write_data1_o == exp_wb1)
        else fail_value("wb data lane 1", exp_wb1, wb_reg_write_data1_o);
    a_pause: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_mem_o == exp_pause)
        else fail_value("pause_mem", exp_pause, pause_mem_o);
    a_exc0: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_exc0_o == exp_exc0)
        else fail_value("commit exc lane 0", exp_exc0, commit_exc0_o);
    a_exc1: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_exc1_o == exp_exc1)
        else fail_value("commit exc lane 1", exp_exc1, commit_exc1_o);
    a_flags: assert property (@(posedge clk) disable iff (!arst_n_i)
        {commit_valid_o, commit_privilege_o, commit_ertn_o, commit_idle_o}
            == {valid_i, is_privilege_i, is_ertn_i, is_idle_i})
        else fail_value("commit flags", {valid_i, is_privilege_i, is_ertn_i, is_idle_i},
                        {commit_valid_o, commit_privilege_o, commit_ertn_o, commit_idle_o});
    a_pc_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
        {commit_pc0_o, commit_pc1_o, commit_addr0_o, commit_addr1_o}
            == {pc0_i, pc1_i, mem_addr0_i, mem_addr1_i})
        else fail_value("commit pc and addr", {pc0_i, pc1_i, mem_addr0_i, mem_addr1_i},
                        {commit_pc0_o, commit_pc1_o, commit_addr0_o, commit_addr1_o});
    a_wb_reg: assert property (@(posedge clk) disable iff (!arst_n_i)
        {wb_reg_write_en_o, wb_reg_write_addr0_o, wb_reg_write_addr1_o}
            == {reg_write_en_i, reg_write_addr0_i, reg_write_addr1_i})
        else fail_value("wb enable and addr", {reg_write_en_i, reg_write_addr0_i,
                        reg_write_addr1_i}, {wb_reg_write_en_o, wb_reg_write_addr0_o,
                        wb_reg_write_addr1_o});

    initial begin
        seed      = 32'h9dc4_39b8;
        test_name = "reset";
        arst_n_i  = 1'b0;
        data_ok_i = 1'b0;
        randomize_sideband();
        wait_falls(RESET_CYCLES);
        arst_n_i = 1'b1;

        load_sweep("byte_loads", `MEM_ALU_LDB, `MEM_ALU_LDBU);
        load_sweep("half_loads", `MEM_ALU_LDH, `MEM_ALU_LDHU);
        load_sweep("word_loads", `MEM_ALU_LDW, `MEM_ALU_LLW);

        test_name = "pass_through";
        for (int k = 0; k < 8; k++) begin
            randomize_sideband();
            data_ok_i = k[0];
            wait_falls(1);
        end

        // ld picks the loading lanes and ex the faulting lane
        test_name = "stall";
        for (int ld = 0; ld < 4; ld++) begin
            for (int ex = 0; ex < 3; ex++) begin
                randomize_sideband();
                data_ok_i = 1'b0;
                if (ld[0]) begin
                    aluop0_i = LOAD_OPS[$unsigned(rand_word()) % 6];
                end
                if (ld[1]) begin
                    aluop1_i = LOAD_OPS[$unsigned(rand_word()) % 6];
                end
                if (ex == 1) begin
                    exc0_i = exc_in_t'(1) << ($unsigned(rand_word()) % `MEM_EXC_W);
                end else if (ex == 2) begin
                    exc1_i = exc_in_t'(1) << ($unsigned(rand_word()) % `MEM_EXC_W);
                end
                wait_falls(1);
            end
        end

        test_name = "forwarding";
        for (int k = 0; k < 24; k++) begin
            randomize_sideband();
            aluop0_i  = k[0] ? LOAD_OPS[$unsigned(rand_word()) % 6] : aluop0_i;
            aluop1_i  = k[1] ? LOAD_OPS[$unsigned(rand_word()) % 6] : aluop1_i;
            exc0_i    = exc_in_t'(rand_word());
            exc1_i    = exc_in_t'(rand_word());
            data_ok_i = 1'(rand_word());
            wait_falls(1);
        end

        wait_falls(2);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
